/* bytePacker.sv */
// Packs bytes into 32-bit words, first byte into bits 31:24
// push_o and word_o are combinational with the fourth byte or the flush
// A flush with no bytes held does nothing, a byte wins over a flush
`timescale 1ns/10ps

module bytePacker
    import sdmacDataPkg::*;
(
    input  logic       nSCLK,
    input  logic       nAS_,
    input  logic       byteValid_i,
    input  logic [7:0] byteData_i,
    input  logic       flush_i,
    output logic       push_o,
    output fifoWordT   word_o,
    output logic [1:0] held_o
);

    logic [31:0] acc;
    logic [3:0]  heldLanes;
    logic [31:0] laneBits;
    logic        lastByte;

    assign lastByte  = byteValid_i && held_o == 2'd3;
    assign push_o    = lastByte || (flush_i && !byteValid_i && held_o != 2'd0);
    assign heldLanes = ~(4'hF >> held_o);  // Top held_o lanes set
    assign laneBits  = {{8{heldLanes[3]}}, {8{heldLanes[2]}},
                        {8{heldLanes[1]}}, {8{heldLanes[0]}}};

    always_comb begin
        if (lastByte) begin
            word_o.data  = {acc[31:8], byteData_i};
            word_o.lanes = 4'hF;
        end else begin
            word_o.data  = acc & laneBits;  // Zero pad unused lanes
            word_o.lanes = heldLanes;
        end
    end

    always_ff @(posedge nSCLK or negedge nAS_) begin
        if (!nAS_)
            held_o <= 2'd0;
        else if (byteValid_i)
            held_o <= held_o + 2'd1;        // Wraps to 0 on the fourth byte
        else if (push_o)
            held_o <= 2'd0;
    end

    // Lane base is (3 - held) * 8
    always_ff @(posedge nSCLK) begin
        if (byteValid_i)
            acc[{~held_o, 3'b000} +: 8] <= byteData_i;
    end

endmodule

/* dmaCtrl.sv */
// Central DMA sequencer, fill side and drain side run concurrently
// Only one peripheral read is in flight at a time
// Memory request holds address, data and enables until acknowledged
`timescale 1ns/10ps
`include "sdmac_macros.svh"

module dmaCtrl
    import sdmacDataPkg::*;
(
    input  logic        nSCLK,
    input  logic        nAS_,
    input  logic        dmaEna_i,
    input  logic        flushReq_i,
    input  byteCntT     curCount_i,
    input  logic        dreq_i,
    input  logic        portBusy_i,
    input  logic [$clog2(`SDMAC_ADDR_STEP)-1:0] packerHeld_i,
    input  logic        fifoEmpty_i,
    input  logic        fifoFull_i,
    input  fifoWordT    fifoHead_i,
    input  logic        memAck_i,
    input  logic [31:0] curAddr_i,
    output logic        rdStart_o,
    output logic        flush_o,
    output logic        fifoPop_o,
    output logic        memReq_o,
    output logic [31:0] memAddr_o,
    output logic [31:0] memData_o,
    output logic [3:0]  memBe_o,
    output logic        wordWritten_o,
    output logic        done_o,
    output logic        busy_o
);

    typedef enum logic [1:0] {FILL_IDLE, FILL_RUN, FILL_END} fillStateT;

    fillStateT fillState;
    logic      stopReq;     // CPU flush seen, finish after the current read
    logic      endReq;
    logic      packerEmpty;

    assign endReq      = (curCount_i == '0) || stopReq;
    assign packerEmpty = packerHeld_i == '0;

    // Fill side
    assign rdStart_o = fillState == FILL_RUN && !endReq && dreq_i && !portBusy_i && !fifoFull_i;
    assign flush_o   = fillState == FILL_RUN && endReq && !portBusy_i && !packerEmpty
                       && !fifoFull_i;
    assign done_o    = fillState == FILL_END && fifoEmpty_i && !memReq_o;
    assign busy_o    = fillState != FILL_IDLE;

    // Drain side retires one word per ack
    assign fifoPop_o     = memReq_o && memAck_i;
    assign wordWritten_o = fifoPop_o;

    always_ff @(posedge nSCLK or negedge nAS_) begin
        if (!nAS_) begin
            fillState <= FILL_IDLE;
            stopReq   <= 1'b0;
        end else begin
            if (done_o)
                stopReq <= 1'b0;
            else if (flushReq_i && busy_o)
                stopReq <= 1'b1;

            unique case (fillState)
                FILL_IDLE: if (dmaEna_i) fillState <= FILL_RUN;
                FILL_RUN: begin
                    // Leave once the partial word, if any, has gone to the FIFO
                    if (endReq && !portBusy_i && (packerEmpty || !fifoFull_i))
                        fillState <= FILL_END;
                end
                FILL_END: if (done_o) fillState <= FILL_IDLE;
                default:  fillState <= FILL_IDLE;
            endcase
        end
    end

    always_ff @(posedge nSCLK or negedge nAS_) begin
        if (!nAS_)
            memReq_o <= 1'b0;
        else if (memReq_o) begin
            if (memAck_i)
                memReq_o <= 1'b0;   // At least one idle cycle between words
        end else if (!fifoEmpty_i)
            memReq_o <= 1'b1;
    end

    always_ff @(posedge nSCLK) begin
        if (!memReq_o && !fifoEmpty_i) begin
            memAddr_o <= curAddr_i;
            memData_o <= fifoHead_i.data;
            memBe_o   <= fifoHead_i.lanes;
        end
    end

endmodule

/* periphPort.sv */
// Peripheral read cycle generator
// DACK and IOR fall one clock after rdStart and stay low SDMAC_IOR_CYC clocks
// Byte is sampled in the last low clock, byteValid follows on the next
// rdStart is ignored while a read is in progress
`timescale 1ns/10ps
`include "sdmac_macros.svh"

module periphPort (
    input  logic       nSCLK,
    input  logic       nAS_,
    input  logic       rdStart_i,
    input  logic [7:0] pd_i,
    output logic       nDack_o,
    output logic       nIor_o,
    output logic       byteValid_o,
    output logic [7:0] byteData_o,
    output logic       busy_o
);

    localparam int CNT_W = $clog2(`SDMAC_IOR_CYC + 1);

    logic             active;
    logic [CNT_W-1:0] strobeCnt;    // Clocks left after this one

    assign nDack_o = ~active;
    assign nIor_o  = ~active;
    assign busy_o  = active | byteValid_o;  // Covers the count update cycle too

    always_ff @(posedge nSCLK or negedge nAS_) begin
        if (!nAS_) begin
            active      <= 1'b0;
            strobeCnt   <= '0;
            byteValid_o <= 1'b0;
        end else begin
            byteValid_o <= 1'b0;
            if (active) begin
                if (strobeCnt == '0) begin
                    active      <= 1'b0;
                    byteValid_o <= 1'b1;
                end else
                    strobeCnt <= strobeCnt - 1'b1;
            end else if (rdStart_i) begin
                active    <= 1'b1;
                strobeCnt <= CNT_W'(`SDMAC_IOR_CYC - 1);
            end
        end
    end

    always_ff @(posedge nSCLK) begin
        if (active && strobeCnt == '0)
            byteData_o <= pd_i;
    end

endmodule

/* regFile.sv */
// CPU register block with live address and byte counters
// Accesses are single-cycle strobes, acknowledged one clock later
// ADDR and COUNT are the running counters, so reads show progress
`timescale 1ns/10ps
`include "sdmac_macros.svh"

module regFile
    import sdmacRegPkg::*;
    import sdmacDataPkg::*;
(
    input  logic        nSCLK,
    input  logic        nAS_,
    input  logic        cpuSel_i,
    input  logic        cpuWr_i,
    input  regAddrT     cpuAddr_i,
    input  logic [31:0] cpuWdata_i,
    input  logic        byteTaken_i,
    input  logic        wordWritten_i,
    input  logic        done_i,
    input  logic        fifoEmpty_i,
    input  logic        fifoFull_i,
    input  logic        busy_i,
    output logic [31:0] cpuRdata_o,
    output logic        cpuAck_o,
    output logic        dmaEna_o,
    output logic        flushReq_o,
    output logic [31:0] curAddr_o,
    output byteCntT     curCount_o,
    output logic        nInt_o
);

    logic   wrStrobe;
    logic   intPending;
    statusT status;

    assign wrStrobe = cpuSel_i && cpuWr_i;
    assign status   = '{fifoEmpty: fifoEmpty_i, intPending: intPending,
                        fifoFull: fifoFull_i, busy: busy_i};
    assign nInt_o   = ~intPending;

    always_ff @(posedge nSCLK or negedge nAS_) begin
        if (!nAS_) begin
            cpuAck_o   <= 1'b0;
            flushReq_o <= 1'b0;
            dmaEna_o   <= 1'b0;
            intPending <= 1'b0;
            curAddr_o  <= '0;
            curCount_o <= '0;
        end else begin
            cpuAck_o   <= cpuSel_i;
            flushReq_o <= wrStrobe && cpuAddr_i == CTRL && cpuWdata_i[`SDMAC_CTRL_FLUSH];

            if (done_i)
                dmaEna_o <= 1'b0;   // Transfer finished, drop enable
            else if (wrStrobe && cpuAddr_i == CTRL)
                dmaEna_o <= cpuWdata_i[`SDMAC_CTRL_ENA];

            if (done_i)
                intPending <= 1'b1;
            else if (wrStrobe && cpuAddr_i == STATUS && cpuWdata_i[`SDMAC_INT_BIT])
                intPending <= 1'b0;

            if (wrStrobe && cpuAddr_i == ADDR)
                curAddr_o <= cpuWdata_i;
            else if (wordWritten_i)
                curAddr_o <= curAddr_o + 32'(`SDMAC_ADDR_STEP);

            if (wrStrobe && cpuAddr_i == COUNT)
                curCount_o <= cpuWdata_i[15:0];
            else if (byteTaken_i)
                curCount_o <= curCount_o - 1'b1;
        end
    end

    // Read data lines up with the ack
    always_ff @(posedge nSCLK) begin
        if (cpuSel_i && !cpuWr_i) begin
            unique case (cpuAddr_i)
                CTRL:   cpuRdata_o <= 32'(dmaEna_o) << `SDMAC_CTRL_ENA;
                ADDR:   cpuRdata_o <= curAddr_o;
                STATUS: cpuRdata_o <= {28'b0, status};
                COUNT:  cpuRdata_o <= {16'b0, curCount_o};
            endcase
        end
    end

endmodule

/* sdmacDataPkg.sv */
// Types for data moving from the peripheral port to memory
// Lane bit 3 marks data bits 31:24 (big-endian packing)
package sdmacDataPkg;

    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  lanes;     // Byte enables
    } fifoWordT;

    typedef logic [15:0] byteCntT;     // Up to 64K-1 bytes per transfer

endpackage

/* sdmacRegPkg.sv */
// Register map types as the CPU sees them
// Register addresses are word indices, not byte offsets
package sdmacRegPkg;

    typedef enum logic [1:0] {
        CTRL   = 2'd0,
        ADDR   = 2'd1,
        STATUS = 2'd2,
        COUNT  = 2'd3
    } regAddrT;

    // Occupies STATUS bits 3:0, intPending lands on bit 2
    typedef struct packed {
        logic fifoEmpty;
        logic intPending;
        logic fifoFull;
        logic busy;
    } statusT;

endpackage

/* sdmacTop.f */
+incdir+.
sdmacRegPkg.sv
sdmacDataPkg.sv
regFile.sv
dmaCtrl.sv
periphPort.sv
bytePacker.sv
wordFifo.sv
sdmacTop.sv
sdmacTop_sva.sv
sdmacTop_tb.sv

/* sdmacTop.sv */
// SCSI DMA controller top, peripheral to memory only
// No bus arbitration, memory port is a request held until memAck_i
// All ports are plain unidirectional signals
`timescale 1ns/10ps

module sdmacTop
    import sdmacRegPkg::*;
    import sdmacDataPkg::*;
(
    input  logic        nSCLK,
    input  logic        nAS_,
    input  logic        cpuSel_i,
    input  logic        cpuWr_i,
    input  regAddrT     cpuAddr_i,
    input  logic [31:0] cpuWdata_i,
    input  logic        dreq_i,
    input  logic [7:0]  pd_i,
    input  logic        memAck_i,
    output logic [31:0] cpuRdata_o,
    output logic        cpuAck_o,
    output logic        nDack_o,
    output logic        nIor_o,
    output logic        memReq_o,
    output logic [31:0] memAddr_o,
    output logic [31:0] memData_o,
    output logic [3:0]  memBe_o,
    output logic        nInt_o
);

    logic        dmaEna, flushReq, done, dmaBusy, wordWritten;
    logic [31:0] curAddr;
    byteCntT     curCount;
    logic        rdStart, portBusy, byteValid;
    logic [7:0]  byteData;
    logic        flush, push;
    logic [1:0]  held;
    fifoWordT    packWord, fifoHead;
    logic        fifoPop, fifoEmpty, fifoFull;

    regFile uRegFile (
        .nSCLK        (nSCLK),        .nAS_       (nAS_),
        .cpuSel_i     (cpuSel_i),     .cpuWr_i    (cpuWr_i),
        .cpuAddr_i    (cpuAddr_i),    .cpuWdata_i (cpuWdata_i),
        .byteTaken_i  (byteValid),    .wordWritten_i (wordWritten),
        .done_i       (done),         .fifoEmpty_i   (fifoEmpty),
        .fifoFull_i   (fifoFull),     .busy_i        (dmaBusy),
        .cpuRdata_o   (cpuRdata_o),   .cpuAck_o      (cpuAck_o),
        .dmaEna_o     (dmaEna),       .flushReq_o    (flushReq),
        .curAddr_o    (curAddr),      .curCount_o    (curCount),
        .nInt_o       (nInt_o)
    );

    dmaCtrl uDmaCtrl (
        .nSCLK        (nSCLK),        .nAS_          (nAS_),
        .dmaEna_i     (dmaEna),       .flushReq_i    (flushReq),
        .curCount_i   (curCount),     .dreq_i        (dreq_i),
        .portBusy_i   (portBusy),     .packerHeld_i  (held),
        .fifoEmpty_i  (fifoEmpty),    .fifoFull_i    (fifoFull),
        .fifoHead_i   (fifoHead),     .memAck_i      (memAck_i),
        .curAddr_i    (curAddr),      .rdStart_o     (rdStart),
        .flush_o      (flush),        .fifoPop_o     (fifoPop),
        .memReq_o     (memReq_o),     .memAddr_o     (memAddr_o),
        .memData_o    (memData_o),    .memBe_o       (memBe_o),
        .wordWritten_o (wordWritten), .done_o        (done),
        .busy_o       (dmaBusy)
    );

    periphPort uPeriphPort (
        .nSCLK       (nSCLK),     .nAS_       (nAS_),
        .rdStart_i   (rdStart),   .pd_i       (pd_i),
        .nDack_o     (nDack_o),   .nIor_o     (nIor_o),
        .byteValid_o (byteValid), .byteData_o (byteData),
        .busy_o      (portBusy)
    );

    bytePacker uBytePacker (
        .nSCLK       (nSCLK),     .nAS_       (nAS_),
        .byteValid_i (byteValid), .byteData_i (byteData),
        .flush_i     (flush),     .push_o     (push),
        .word_o      (packWord),  .held_o     (held)
    );

    wordFifo #(.ELEM_T(fifoWordT)) uWordFifo (
        .nSCLK   (nSCLK),     .nAS_    (nAS_),
        .push_i  (push),      .din_i   (packWord),
        .pop_i   (fifoPop),   .head_o  (fifoHead),
        .empty_o (fifoEmpty), .full_o  (fifoFull)
    );

endmodule

/* sdmacTop_sva.sv */
// Protocol checks on the sdmacTop ports, attached by bind
// Failures are counted in svaErrs, the testbench reads it at the end
// Checks are off while nAS_ is low
`timescale 1ns/10ps
`include "sdmac_macros.svh"

module sdmacTop_sva (
    input logic        nSCLK,
    input logic        nAS_,
    input logic        dreq_i,
    input logic        nDack_o,
    input logic        nIor_o,
    input logic        memReq_o,
    input logic        memAck_i,
    input logic [31:0] memAddr_o,
    input logic [31:0] memData_o,
    input logic [3:0]  memBe_o
);

    int svaErrs = 0;

    // Request and its payload hold until acknowledged
    memHold: assert property (@(posedge nSCLK) disable iff (!nAS_)
        memReq_o && !memAck_i |=> memReq_o && $stable(memAddr_o)
                                  && $stable(memData_o) && $stable(memBe_o))
        else begin
            svaErrs++;
            $error("Memory request dropped or changed before memAck_i");
        end

    // Strobes low together for SDMAC_IOR_CYC clocks, then high together
    strobeWidth: assert property (@(posedge nSCLK) disable iff (!nAS_)
        $fell(nIor_o) |-> (!nIor_o && !nDack_o) [*`SDMAC_IOR_CYC] ##1 (nIor_o && nDack_o))
        else begin
            svaErrs++;
            $error("nIor_o low without nDack_o or for the wrong number of clocks");
        end

    // No new read cycle may start without DREQ
    noReadWithoutDreq: assert property (@(posedge nSCLK) disable iff (!nAS_)
        !dreq_i && nDack_o && nIor_o |=> nDack_o && nIor_o)
        else begin
            svaErrs++;
            $error("Read strobes fell while dreq_i was low");
        end

endmodule

bind sdmacTop sdmacTop_sva uSva (
    .nSCLK     (nSCLK),
    .nAS_      (nAS_),
    .dreq_i    (dreq_i),
    .nDack_o   (nDack_o),
    .nIor_o    (nIor_o),
    .memReq_o  (memReq_o),
    .memAck_i  (memAck_i),
    .memAddr_o (memAddr_o),
    .memData_o (memData_o),
    .memBe_o   (memBe_o)
);

/* sdmacTop_tb.sv */
// Testbench for sdmacTop with peripheral and memory models
// Random bytes, DREQ gaps and memAck delays come from one LFSR, seed 81490
// Expected writes are rebuilt from the bytes the peripheral model has sent
// Run ends early on a watchdog scaled to the total programmed byte count
`timescale 1ns/10ps
`include "sdmac_macros.svh"

module sdmacTop_tb
    import sdmacRegPkg::*;
();

    localparam int PERIOD      = 100;
    localparam int ALIGN_CNT   = 32;
    localparam int UNALIGN_CNT = 23;
    localparam int STRESS_CNT  = 50;
    localparam int FLUSH_CNT   = 40;
    localparam int TOTAL_BYTES = ALIGN_CNT + UNALIGN_CNT + STRESS_CNT + FLUSH_CNT;
    localparam int TIMEOUT_CYC = TOTAL_BYTES * 20 + 2000;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0]  be;
    } memWriteT;
    typedef memWriteT    writeQ[$];
    typedef logic [7:0]  byteQ[$];

    logic        nSCLK = 1'b0;
    logic        nAS_;
    logic        cpuSel_i, cpuWr_i;
    regAddrT     cpuAddr_i;
    logic [31:0] cpuWdata_i, cpuRdata_o;
    logic        cpuAck_o, dreq_i, memAck_i, nDack_o, nIor_o, memReq_o, nInt_o;
    logic [7:0]  pd_i;
    logic [31:0] memAddr_o, memData_o;
    logic [3:0]  memBe_o;

    logic [31:0] lfsr;
    logic        stress = 1'b0;     // Random DREQ gaps and ack delays
    logic        prevIor = 1'b1;
    logic [1:0]  ackWait = 2'd0;
    byteQ        sentQ;
    logic [31:0] baseAddr = '0;
    int          wordIdx = 0;
    int          valueErrs = 0;
    int          otherErrs = 0;

    sdmacTop dut (.*);

    always #(PERIOD / 2) nSCLK = ~nSCLK;

    // Galois LFSR, x^32 + x^22 + x^2 + x + 1, one step per bit
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[0];
            lfsr = lfsr >> 1;
            if (fb)
                lfsr = lfsr ^ 32'h8020_0003;
            val = {val[30:0], fb};
        end
        return val;
    endfunction

    // Big-endian packing, last word zero padded with its lanes cleared
    function automatic writeQ packWords(input byteQ bytes, input logic [31:0] base);
        writeQ    words;
        memWriteT w;
        int       lane;
        w = '0;
        for (int i = 0; i < bytes.size(); i++) begin
            lane = i % 4;
            w.data[31 - 8 * lane -: 8] = bytes[i];
            w.be[3 - lane] = 1'b1;
            if (lane == 3 || i == bytes.size() - 1) begin
                w.addr = base + 32'((i / 4) * `SDMAC_ADDR_STEP);
                words.push_back(w);
                w = '0;
            end
        end
        return words;
    endfunction

    task automatic compareValue(input string name, input logic [31:0] expVal,
                                input logic [31:0] gotVal);
        assert (gotVal === expVal) else begin
            valueErrs++;
            $display("ERR t=%0t %s expected %h got %h", $time, name, expVal, gotVal);
        end
    endtask

    task automatic requireTrue(input logic cond, input string what);
        assert (cond) else begin
            otherErrs++;
            $display("Check failed at %0t: %s", $time, what);
        end
    endtask

    // One strobe cycle, ack expected on the following cycle
    task automatic cpuAccess(input regAddrT addr, input logic wr,
                             input logic [31:0] wdata, output logic [31:0] rdata);
        @(posedge nSCLK);
        cpuSel_i   <= 1'b1;
        cpuWr_i    <= wr;
        cpuAddr_i  <= addr;
        cpuWdata_i <= wdata;
        @(negedge nSCLK);
        requireTrue(!cpuAck_o, "cpuAck_o high during the strobe cycle");
        @(posedge nSCLK);
        cpuSel_i <= 1'b0;
        cpuWr_i  <= 1'b0;
        @(negedge nSCLK);
        requireTrue(cpuAck_o, "no cpuAck_o pulse one cycle after the strobe");
        rdata = cpuRdata_o;
    endtask

    task automatic regWrite(input regAddrT addr, input logic [31:0] data);
        logic [31:0] unused;
        cpuAccess(addr, 1'b1, data, unused);
    endtask

    task automatic regRead(input regAddrT addr, output logic [31:0] data);
        cpuAccess(addr, 1'b0, '0, data);
    endtask

    task automatic clearInterrupt();
        logic [31:0] rd;
        regWrite(STATUS, 32'(1) << `SDMAC_INT_BIT);
        requireTrue(nInt_o, "nInt_o still low after the interrupt clear");
        regRead(STATUS, rd);
        compareValue("cpuRdata_o (STATUS)", 32'h8, rd);    // Only fifoEmpty, bit 3
    endtask

    task automatic runTransfer(input logic [31:0] base, input int count,
                               input logic randomize, input logic flushMid);
        logic [31:0] rd;
        writeQ       refQ;
        stress   = randomize;
        sentQ.delete();
        wordIdx  = 0;
        baseAddr = base;
        regWrite(ADDR, base);
        regWrite(COUNT, 32'(count));
        regWrite(CTRL, 32'(1) << `SDMAC_CTRL_ENA);
        if (flushMid) begin
            while (sentQ.size() < 9)
                @(negedge nSCLK);
            regWrite(CTRL, 32'(1) << `SDMAC_CTRL_FLUSH);
        end
        while (nInt_o)
            @(negedge nSCLK);   // Interrupt marks the end of the last write
        stress = 1'b0;
        refQ = packWords(sentQ, base);
        requireTrue(wordIdx == refQ.size(), "memory write count differs from reference");
        if (flushMid)
            requireTrue(sentQ.size() % 4 != 0, "flush found no bytes held in the packer");
        else
            requireTrue(sentQ.size() == count, "bytes read differ from the programmed count");
        regRead(COUNT, rd);
        compareValue("cpuRdata_o (COUNT)", 32'(count - sentQ.size()), rd);
        clearInterrupt();
    endtask

    // Peripheral and memory models, all random draws in fixed order
    always @(posedge nSCLK) begin
        if (nAS_) begin
            dreq_i <= stress ? (randBits(2) != 0) : 1'b1;
            if (!prevIor && nIor_o) begin       // Read cycle just ended
                sentQ.push_back(pd_i);
                pd_i <= 8'(randBits(8));
            end
            prevIor = nIor_o;
            if (memAck_i) begin
                memAck_i <= 1'b0;
                ackWait  <= stress ? 2'(randBits(2)) : 2'd0;
            end else if (memReq_o) begin
                if (ackWait == 2'd0)
                    memAck_i <= 1'b1;
                else
                    ackWait <= ackWait - 2'd1;
            end
        end
    end

    // Each acknowledged write against the reference
    always @(negedge nSCLK) begin : compareWrites
        writeQ refQ;
        if (nAS_ && memReq_o && memAck_i) begin
            refQ = packWords(sentQ, baseAddr);
            requireTrue(wordIdx < refQ.size(), "memory write beyond the expected words");
            if (wordIdx < refQ.size()) begin
                compareValue("memAddr_o", refQ[wordIdx].addr, memAddr_o);
                compareValue("memData_o", refQ[wordIdx].data, memData_o);
                compareValue("memBe_o", 32'(refQ[wordIdx].be), 32'(memBe_o));
            end
            wordIdx++;
        end
    end

    initial begin
        #(TIMEOUT_CYC * PERIOD);
        $display("Watchdog: run timed out after %0d cycles", TIMEOUT_CYC);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        logic [31:0] rd;
        lfsr       = 32'd81490;
        nAS_       = 1'b0;
        cpuSel_i   = 1'b0;
        cpuWr_i    = 1'b0;
        cpuAddr_i  = CTRL;
        cpuWdata_i = '0;
        dreq_i     = 1'b0;
        memAck_i   = 1'b0;
        pd_i       = 8'(randBits(8));
        repeat (10) @(posedge nSCLK);
        nAS_ <= 1'b1;
        @(negedge nSCLK);

        requireTrue(nInt_o && nDack_o && nIor_o, "nInt_o, nDack_o or nIor_o low after reset");
        requireTrue(!memReq_o && !cpuAck_o, "memReq_o or cpuAck_o high after reset");
        regWrite(ADDR, 32'hCAFE_0010);
        regRead(ADDR, rd);
        compareValue("cpuRdata_o (ADDR)", 32'hCAFE_0010, rd);
        regWrite(COUNT, 32'h0000_1234);
        regRead(COUNT, rd);
        compareValue("cpuRdata_o (COUNT)", 32'h0000_1234, rd);

        runTransfer(32'h0000_1000, ALIGN_CNT, 1'b0, 1'b0);
        runTransfer(32'h0000_2000, UNALIGN_CNT, 1'b0, 1'b0);
        runTransfer(32'h0000_3000, STRESS_CNT, 1'b1, 1'b0);
        runTransfer(32'h0000_4000, FLUSH_CNT, 1'b0, 1'b1);

        $display("Errors: %0d value, %0d other, %0d assertion",
                 valueErrs, otherErrs, dut.uSva.svaErrs);
        if (valueErrs + otherErrs + dut.uSva.svaErrs == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

/* sdmac_macros.svh */
// Shared constants for the SCSI DMA controller
// FIFO depth must stay a power of two
// Address step equals the bytes per bus word
`ifndef SDMAC_MACROS_SVH
`define SDMAC_MACROS_SVH

`define SDMAC_FIFO_DEPTH 4      // Words
`define SDMAC_IOR_CYC 2         // Read strobe low time, clocks

// CTRL register bits
`define SDMAC_CTRL_ENA 0
`define SDMAC_CTRL_FLUSH 1      // Write one to pulse, reads as zero

`define SDMAC_INT_BIT 2         // STATUS bit, write one clears

`define SDMAC_ADDR_STEP 4

`endif

/* wordFifo.sv */
// Synchronous FIFO, first word falls through on head_o
// Push when full and pop when empty are ignored
// Depth from SDMAC_FIFO_DEPTH, must be a power of two
`timescale 1ns/10ps
`include "sdmac_macros.svh"

module wordFifo #(
    parameter type ELEM_T = logic [31:0]
) (
    input  logic  nSCLK,
    input  logic  nAS_,
    input  logic  push_i,
    input  ELEM_T din_i,
    input  logic  pop_i,
    output ELEM_T head_o,
    output logic  empty_o,
    output logic  full_o
);

    localparam int AW = $clog2(`SDMAC_FIFO_DEPTH);

    ELEM_T       mem [`SDMAC_FIFO_DEPTH];
    logic [AW:0] wrPtr;     // Extra MSB tells full from empty
    logic [AW:0] rdPtr;
    logic        doPush;
    logic        doPop;

    assign doPush  = push_i && !full_o;
    assign doPop   = pop_i && !empty_o;
    assign empty_o = wrPtr == rdPtr;
    assign full_o  = (wrPtr[AW] != rdPtr[AW]) && (wrPtr[AW-1:0] == rdPtr[AW-1:0]);
    assign head_o  = mem[rdPtr[AW-1:0]];

    always_ff @(posedge nSCLK or negedge nAS_) begin
        if (!nAS_) begin
            wrPtr <= '0;
            rdPtr <= '0;
        end else begin
            if (doPush)
                wrPtr <= wrPtr + 1'b1;
            if (doPop)
                rdPtr <= rdPtr + 1'b1;
        end
    end

    always_ff @(posedge nSCLK) begin
        if (doPush)
            mem[wrPtr[AW-1:0]] <= din_i;
    end

endmodule
